// ==== include/tmr_axi_cfg.svh ====
`ifndef TMR_AXI_CFG_SVH
`define TMR_AXI_CFG_SVH

// Transaction id width
`define TMR_AXI_ID_W 1

// Byte address width
`define TMR_AXI_ADDR_W 32

// Data bus width, strobe carries one bit per byte of it
`define TMR_AXI_DATA_W 32

`endif

// ==== design/tmr_axi_pkg.sv ====
`default_nettype none

`include "tmr_axi_cfg.svh"

package tmr_axi_pkg;

  // Redundant managers feeding the voter
  localparam int tmr_replicas = 3;

  // Bit k flags replica k as the odd one out
  typedef logic [tmr_replicas-1:0] replica_mask_t;

  // Shared by AW and AR
  typedef struct packed {
    logic [`TMR_AXI_ID_W-1:0]   id;
    logic [`TMR_AXI_ADDR_W-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
    logic                       valid;
  } addr_chan_t;

  typedef struct packed {
    logic [`TMR_AXI_DATA_W-1:0]   data;
    logic [`TMR_AXI_DATA_W/8-1:0] strb;
    logic                         last;
    logic                         valid;
  } wdata_chan_t;

  // Readies that the replicas drive toward the response channels
  typedef struct packed {
    logic bready;
    logic rready;
  } resp_rdy_t;

endpackage

`default_nettype wire

// ==== design/tmr_mismatch_if.sv ====
`default_nettype none

interface tmr_mismatch_if;
  import tmr_axi_pkg::*;

  // One odd-replica mask per voted channel
  replica_mask_t aw_mis;
  replica_mask_t w_mis;
  replica_mask_t ar_mis;
  replica_mask_t rdy_mis;

  modport voter (output aw_mis, w_mis, ar_mis, rdy_mis);

  modport collector (input aw_mis, w_mis, ar_mis, rdy_mis);

endinterface

`default_nettype wire

// ==== design/tmr_vote.sv ====
`default_nettype none

module tmr_vote #(
  parameter type payload_t = logic
) (
  input  payload_t                   a,
  input  payload_t                   b,
  input  payload_t                   c,
  output payload_t                   voted,
  output tmr_axi_pkg::replica_mask_t mismatch
);

  localparam int payload_w = $bits(payload_t);

  logic [payload_w-1:0] a_bits;
  logic [payload_w-1:0] b_bits;
  logic [payload_w-1:0] c_bits;

  assign a_bits = a;
  assign b_bits = b;
  assign c_bits = c;

  // Two out of three per bit
  assign voted = (a_bits & b_bits) | (b_bits & c_bits) | (a_bits & c_bits);

  // A replica is odd at a bit where the other two agree and it does not
  assign mismatch[0] = |((a_bits ^ b_bits) & ~(b_bits ^ c_bits));
  assign mismatch[1] = |((b_bits ^ c_bits) & ~(a_bits ^ c_bits));
  assign mismatch[2] = |((c_bits ^ a_bits) & ~(a_bits ^ b_bits));

endmodule

`default_nettype wire

// ==== design/tmr_fault_flags.sv ====
`default_nettype none

module tmr_fault_flags (
  input  logic                       axi_aclk,
  input  logic                       arst_n,
  tmr_mismatch_if.collector          mis,
  output tmr_axi_pkg::replica_mask_t fault
);
  import tmr_axi_pkg::*;

  replica_mask_t fault_next;

  // Any channel disagreement marks the replica
  assign fault_next = mis.aw_mis | mis.w_mis | mis.ar_mis | mis.rdy_mis;

  // Registered so the wide compare cannot glitch the flags
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      fault <= '0;
    end else begin
      fault <= fault_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/tmr_axi_vote.sv ====
`default_nettype none

`include "tmr_axi_cfg.svh"

module tmr_axi_vote (
  input  logic                         axi_aclk,
  input  logic                         arst_n,
  // Replica 0
  input  logic [`TMR_AXI_ID_W-1:0]     s00_axi_awid,
  input  logic [`TMR_AXI_ADDR_W-1:0]   s00_axi_awaddr,
  input  logic [7:0]                   s00_axi_awlen,
  input  logic [2:0]                   s00_axi_awsize,
  input  logic [1:0]                   s00_axi_awburst,
  input  logic                         s00_axi_awvalid,
  output logic                         s00_axi_awready,
  input  logic [`TMR_AXI_DATA_W-1:0]   s00_axi_wdata,
  input  logic [`TMR_AXI_DATA_W/8-1:0] s00_axi_wstrb,
  input  logic                         s00_axi_wlast,
  input  logic                         s00_axi_wvalid,
  output logic                         s00_axi_wready,
  input  logic                         s00_axi_bready,
  output logic [`TMR_AXI_ID_W-1:0]     s00_axi_bid,
  output logic [1:0]                   s00_axi_bresp,
  output logic                         s00_axi_bvalid,
  input  logic [`TMR_AXI_ID_W-1:0]     s00_axi_arid,
  input  logic [`TMR_AXI_ADDR_W-1:0]   s00_axi_araddr,
  input  logic [7:0]                   s00_axi_arlen,
  input  logic [2:0]                   s00_axi_arsize,
  input  logic [1:0]                   s00_axi_arburst,
  input  logic                         s00_axi_arvalid,
  output logic                         s00_axi_arready,
  input  logic                         s00_axi_rready,
  output logic [`TMR_AXI_ID_W-1:0]     s00_axi_rid,
  output logic [`TMR_AXI_DATA_W-1:0]   s00_axi_rdata,
  output logic [1:0]                   s00_axi_rresp,
  output logic                         s00_axi_rlast,
  output logic                         s00_axi_rvalid,
  // Replica 1
  input  logic [`TMR_AXI_ID_W-1:0]     s01_axi_awid,
  input  logic [`TMR_AXI_ADDR_W-1:0]   s01_axi_awaddr,
  input  logic [7:0]                   s01_axi_awlen,
  input  logic [2:0]                   s01_axi_awsize,
  input  logic [1:0]                   s01_axi_awburst,
  input  logic                         s01_axi_awvalid,
  output logic                         s01_axi_awready,
  input  logic [`TMR_AXI_DATA_W-1:0]   s01_axi_wdata,
  input  logic [`TMR_AXI_DATA_W/8-1:0] s01_axi_wstrb,
  input  logic                         s01_axi_wlast,
  input  logic                         s01_axi_wvalid,
  output logic                         s01_axi_wready,
  input  logic                         s01_axi_bready,
  output logic [`TMR_AXI_ID_W-1:0]     s01_axi_bid,
  output logic [1:0]                   s01_axi_bresp,
  output logic                         s01_axi_bvalid,
  input  logic [`TMR_AXI_ID_W-1:0]     s01_axi_arid,
  input  logic [`TMR_AXI_ADDR_W-1:0]   s01_axi_araddr,
  input  logic [7:0]                   s01_axi_arlen,
  input  logic [2:0]                   s01_axi_arsize,
  input  logic [1:0]                   s01_axi_arburst,
  input  logic                         s01_axi_arvalid,
  output logic                         s01_axi_arready,
  input  logic                         s01_axi_rready,
  output logic [`TMR_AXI_ID_W-1:0]     s01_axi_rid,
  output logic [`TMR_AXI_DATA_W-1:0]   s01_axi_rdata,
  output logic [1:0]                   s01_axi_rresp,
  output logic                         s01_axi_rlast,
  output logic                         s01_axi_rvalid,
  // Replica 2
  input  logic [`TMR_AXI_ID_W-1:0]     s02_axi_awid,
  input  logic [`TMR_AXI_ADDR_W-1:0]   s02_axi_awaddr,
  input  logic [7:0]                   s02_axi_awlen,
  input  logic [2:0]                   s02_axi_awsize,
  input  logic [1:0]                   s02_axi_awburst,
  input  logic                         s02_axi_awvalid,
  output logic                         s02_axi_awready,
  input  logic [`TMR_AXI_DATA_W-1:0]   s02_axi_wdata,
  input  logic [`TMR_AXI_DATA_W/8-1:0] s02_axi_wstrb,
  input  logic                         s02_axi_wlast,
  input  logic                         s02_axi_wvalid,
  output logic                         s02_axi_wready,
  input  logic                         s02_axi_bready,
  output logic [`TMR_AXI_ID_W-1:0]     s02_axi_bid,
  output logic [1:0]                   s02_axi_bresp,
  output logic                         s02_axi_bvalid,
  input  logic [`TMR_AXI_ID_W-1:0]     s02_axi_arid,
  input  logic [`TMR_AXI_ADDR_W-1:0]   s02_axi_araddr,
  input  logic [7:0]                   s02_axi_arlen,
  input  logic [2:0]                   s02_axi_arsize,
  input  logic [1:0]                   s02_axi_arburst,
  input  logic                         s02_axi_arvalid,
  output logic                         s02_axi_arready,
  input  logic                         s02_axi_rready,
  output logic [`TMR_AXI_ID_W-1:0]     s02_axi_rid,
  output logic [`TMR_AXI_DATA_W-1:0]   s02_axi_rdata,
  output logic [1:0]                   s02_axi_rresp,
  output logic                         s02_axi_rlast,
  output logic                         s02_axi_rvalid,
  // Downstream manager port
  input  logic                         m00_axi_awready,
  output logic [`TMR_AXI_ID_W-1:0]     m00_axi_awid,
  output logic [`TMR_AXI_ADDR_W-1:0]   m00_axi_awaddr,
  output logic [7:0]                   m00_axi_awlen,
  output logic [2:0]                   m00_axi_awsize,
  output logic [1:0]                   m00_axi_awburst,
  output logic                         m00_axi_awvalid,
  input  logic                         m00_axi_wready,
  output logic [`TMR_AXI_DATA_W-1:0]   m00_axi_wdata,
  output logic [`TMR_AXI_DATA_W/8-1:0] m00_axi_wstrb,
  output logic                         m00_axi_wlast,
  output logic                         m00_axi_wvalid,
  input  logic [`TMR_AXI_ID_W-1:0]     m00_axi_bid,
  input  logic [1:0]                   m00_axi_bresp,
  input  logic                         m00_axi_bvalid,
  output logic                         m00_axi_bready,
  input  logic                         m00_axi_arready,
  output logic [`TMR_AXI_ID_W-1:0]     m00_axi_arid,
  output logic [`TMR_AXI_ADDR_W-1:0]   m00_axi_araddr,
  output logic [7:0]                   m00_axi_arlen,
  output logic [2:0]                   m00_axi_arsize,
  output logic [1:0]                   m00_axi_arburst,
  output logic                         m00_axi_arvalid,
  input  logic [`TMR_AXI_ID_W-1:0]     m00_axi_rid,
  input  logic [`TMR_AXI_DATA_W-1:0]   m00_axi_rdata,
  input  logic [1:0]                   m00_axi_rresp,
  input  logic                         m00_axi_rlast,
  input  logic                         m00_axi_rvalid,
  output logic                         m00_axi_rready,
  output logic                         fault0,
  output logic                         fault1,
  output logic                         fault2
);
  import tmr_axi_pkg::*;

  addr_chan_t    aw_rep [tmr_replicas];
  wdata_chan_t   w_rep [tmr_replicas];
  addr_chan_t    ar_rep [tmr_replicas];
  resp_rdy_t     rdy_rep [tmr_replicas];
  addr_chan_t    aw_voted;
  wdata_chan_t   w_voted;
  addr_chan_t    ar_voted;
  resp_rdy_t     rdy_voted;
  replica_mask_t fault;

  tmr_mismatch_if mis_if ();

  // Field order follows the struct, id first
  assign aw_rep[0] = {s00_axi_awid, s00_axi_awaddr, s00_axi_awlen,
                      s00_axi_awsize, s00_axi_awburst, s00_axi_awvalid};
  assign aw_rep[1] = {s01_axi_awid, s01_axi_awaddr, s01_axi_awlen,
                      s01_axi_awsize, s01_axi_awburst, s01_axi_awvalid};
  assign aw_rep[2] = {s02_axi_awid, s02_axi_awaddr, s02_axi_awlen,
                      s02_axi_awsize, s02_axi_awburst, s02_axi_awvalid};

  assign w_rep[0] = {s00_axi_wdata, s00_axi_wstrb, s00_axi_wlast, s00_axi_wvalid};
  assign w_rep[1] = {s01_axi_wdata, s01_axi_wstrb, s01_axi_wlast, s01_axi_wvalid};
  assign w_rep[2] = {s02_axi_wdata, s02_axi_wstrb, s02_axi_wlast, s02_axi_wvalid};

  assign ar_rep[0] = {s00_axi_arid, s00_axi_araddr, s00_axi_arlen,
                      s00_axi_arsize, s00_axi_arburst, s00_axi_arvalid};
  assign ar_rep[1] = {s01_axi_arid, s01_axi_araddr, s01_axi_arlen,
                      s01_axi_arsize, s01_axi_arburst, s01_axi_arvalid};
  assign ar_rep[2] = {s02_axi_arid, s02_axi_araddr, s02_axi_arlen,
                      s02_axi_arsize, s02_axi_arburst, s02_axi_arvalid};

  assign rdy_rep[0] = {s00_axi_bready, s00_axi_rready};
  assign rdy_rep[1] = {s01_axi_bready, s01_axi_rready};
  assign rdy_rep[2] = {s02_axi_bready, s02_axi_rready};

  tmr_vote #(.payload_t(addr_chan_t)) aw_vote (
    .a        (aw_rep[0]),
    .b        (aw_rep[1]),
    .c        (aw_rep[2]),
    .voted    (aw_voted),
    .mismatch (mis_if.aw_mis)
  );

  tmr_vote #(.payload_t(wdata_chan_t)) w_vote (
    .a        (w_rep[0]),
    .b        (w_rep[1]),
    .c        (w_rep[2]),
    .voted    (w_voted),
    .mismatch (mis_if.w_mis)
  );

  tmr_vote #(.payload_t(addr_chan_t)) ar_vote (
    .a        (ar_rep[0]),
    .b        (ar_rep[1]),
    .c        (ar_rep[2]),
    .voted    (ar_voted),
    .mismatch (mis_if.ar_mis)
  );

  tmr_vote #(.payload_t(resp_rdy_t)) rdy_vote (
    .a        (rdy_rep[0]),
    .b        (rdy_rep[1]),
    .c        (rdy_rep[2]),
    .voted    (rdy_voted),
    .mismatch (mis_if.rdy_mis)
  );

  assign {m00_axi_awid, m00_axi_awaddr, m00_axi_awlen,
          m00_axi_awsize, m00_axi_awburst, m00_axi_awvalid} = aw_voted;
  assign {m00_axi_wdata, m00_axi_wstrb, m00_axi_wlast, m00_axi_wvalid} = w_voted;
  assign {m00_axi_arid, m00_axi_araddr, m00_axi_arlen,
          m00_axi_arsize, m00_axi_arburst, m00_axi_arvalid} = ar_voted;
  assign {m00_axi_bready, m00_axi_rready} = rdy_voted;

  tmr_fault_flags fault_flags (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .mis      (mis_if),
    .fault    (fault)
  );

  assign {fault2, fault1, fault0} = fault;

  // Back-pressure and responses reach every replica in the same cycle
  assign {s00_axi_awready, s00_axi_wready, s00_axi_arready} =
         {m00_axi_awready, m00_axi_wready, m00_axi_arready};
  assign {s01_axi_awready, s01_axi_wready, s01_axi_arready} =
         {m00_axi_awready, m00_axi_wready, m00_axi_arready};
  assign {s02_axi_awready, s02_axi_wready, s02_axi_arready} =
         {m00_axi_awready, m00_axi_wready, m00_axi_arready};

  assign {s00_axi_bid, s00_axi_bresp, s00_axi_bvalid} = {m00_axi_bid, m00_axi_bresp, m00_axi_bvalid};
  assign {s01_axi_bid, s01_axi_bresp, s01_axi_bvalid} = {m00_axi_bid, m00_axi_bresp, m00_axi_bvalid};
  assign {s02_axi_bid, s02_axi_bresp, s02_axi_bvalid} = {m00_axi_bid, m00_axi_bresp, m00_axi_bvalid};

  assign {s00_axi_rid, s00_axi_rdata, s00_axi_rresp, s00_axi_rlast, s00_axi_rvalid} =
         {m00_axi_rid, m00_axi_rdata, m00_axi_rresp, m00_axi_rlast, m00_axi_rvalid};
  assign {s01_axi_rid, s01_axi_rdata, s01_axi_rresp, s01_axi_rlast, s01_axi_rvalid} =
         {m00_axi_rid, m00_axi_rdata, m00_axi_rresp, m00_axi_rlast, m00_axi_rvalid};
  assign {s02_axi_rid, s02_axi_rdata, s02_axi_rresp, s02_axi_rlast, s02_axi_rvalid} =
         {m00_axi_rid, m00_axi_rdata, m00_axi_rresp, m00_axi_rlast, m00_axi_rvalid};

endmodule

`default_nettype wire

// ==== dv/tmr_axi_vote_assert.sv ====
`default_nettype none

module tmr_axi_vote_assert (
  input wire       axi_aclk,
  input wire       arst_n,
  input wire [2:0] fault,
  input wire       agree,
  input wire [4:0] rdy0,
  input wire [4:0] rdy1,
  input wire [4:0] rdy2,
  input wire [4:0] rdy_m00
);
  timeunit 1ns;
  timeprecision 1ps;

  fault_low_in_reset: assert property (@(posedge axi_aclk) !arst_n |-> fault == 3'b000)
    else $error("fault flag high while in reset");

  // Agreeing replicas leave no fault behind
  no_fault_after_agree: assert property (@(posedge axi_aclk) disable iff (!arst_n)
    agree |=> fault == 3'b000)
    else $error("fault flag high after a cycle of agreeing replicas");

  fanout_s00: assert property (@(posedge axi_aclk) rdy0 == rdy_m00)
    else $error("s00 ready or valid differs from m00");
  fanout_s01: assert property (@(posedge axi_aclk) rdy1 == rdy_m00)
    else $error("s01 ready or valid differs from m00");
  fanout_s02: assert property (@(posedge axi_aclk) rdy2 == rdy_m00)
    else $error("s02 ready or valid differs from m00");

endmodule

bind tmr_axi_vote tmr_axi_vote_assert assert_inst (
  .axi_aclk (axi_aclk),
  .arst_n   (arst_n),
  .fault    ({fault2, fault1, fault0}),
  .agree    (aw_rep[0] == aw_rep[1] && aw_rep[1] == aw_rep[2] &&
             w_rep[0] == w_rep[1] && w_rep[1] == w_rep[2] &&
             ar_rep[0] == ar_rep[1] && ar_rep[1] == ar_rep[2] &&
             rdy_rep[0] == rdy_rep[1] && rdy_rep[1] == rdy_rep[2]),
  .rdy0     ({s00_axi_awready, s00_axi_wready, s00_axi_arready, s00_axi_bvalid, s00_axi_rvalid}),
  .rdy1     ({s01_axi_awready, s01_axi_wready, s01_axi_arready, s01_axi_bvalid, s01_axi_rvalid}),
  .rdy2     ({s02_axi_awready, s02_axi_wready, s02_axi_arready, s02_axi_bvalid, s02_axi_rvalid}),
  .rdy_m00  ({m00_axi_awready, m00_axi_wready, m00_axi_arready, m00_axi_bvalid, m00_axi_rvalid})
);

`default_nettype wire

// ==== include/tmr_axi_tb_cfg.svh ====
`ifndef TMR_AXI_TB_CFG_SVH
`define TMR_AXI_TB_CFG_SVH

// Cycles of seeded random replica traffic after reset
`define TMR_TB_CYCLES 2000

// Reset length in clock cycles
`define TMR_TB_RST_CYCLES 8

`endif

// ==== dv/tmr_axi_vote_tb.sv ====
`default_nettype none

`include "tmr_axi_cfg.svh"
`include "tmr_axi_tb_cfg.svh"

module tmr_axi_vote_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int aw_w = `TMR_AXI_ID_W + `TMR_AXI_ADDR_W + 14;
  localparam int w_w = `TMR_AXI_DATA_W + `TMR_AXI_DATA_W / 8 + 2;
  // Flat replica request with aw at the top, then w, ar, bready and rready
  localparam int req_w = 2 * aw_w + w_w + 2;
  localparam int resp_w = 10 + 2 * `TMR_AXI_ID_W + `TMR_AXI_DATA_W;
  localparam int total_cycles = `TMR_TB_RST_CYCLES + `TMR_TB_CYCLES;
  // Reset, traffic and a margin
  localparam int max_cycles = total_cycles + 192;

  logic axi_aclk, arst_n, fault0, fault1, fault2;
  logic [`TMR_AXI_ID_W-1:0] s00_axi_awid, s01_axi_awid, s02_axi_awid, m00_axi_awid,
    s00_axi_arid, s01_axi_arid, s02_axi_arid, m00_axi_arid,
    s00_axi_bid, s01_axi_bid, s02_axi_bid, m00_axi_bid,
    s00_axi_rid, s01_axi_rid, s02_axi_rid, m00_axi_rid;
  logic [`TMR_AXI_ADDR_W-1:0] s00_axi_awaddr, s01_axi_awaddr, s02_axi_awaddr, m00_axi_awaddr,
    s00_axi_araddr, s01_axi_araddr, s02_axi_araddr, m00_axi_araddr;
  logic [7:0] s00_axi_awlen, s01_axi_awlen, s02_axi_awlen, m00_axi_awlen,
    s00_axi_arlen, s01_axi_arlen, s02_axi_arlen, m00_axi_arlen;
  logic [2:0] s00_axi_awsize, s01_axi_awsize, s02_axi_awsize, m00_axi_awsize,
    s00_axi_arsize, s01_axi_arsize, s02_axi_arsize, m00_axi_arsize;
  logic [1:0] s00_axi_awburst, s01_axi_awburst, s02_axi_awburst, m00_axi_awburst,
    s00_axi_arburst, s01_axi_arburst, s02_axi_arburst, m00_axi_arburst,
    s00_axi_bresp, s01_axi_bresp, s02_axi_bresp, m00_axi_bresp,
    s00_axi_rresp, s01_axi_rresp, s02_axi_rresp, m00_axi_rresp;
  logic [`TMR_AXI_DATA_W-1:0] s00_axi_wdata, s01_axi_wdata, s02_axi_wdata, m00_axi_wdata,
    s00_axi_rdata, s01_axi_rdata, s02_axi_rdata, m00_axi_rdata;
  logic [`TMR_AXI_DATA_W/8-1:0] s00_axi_wstrb, s01_axi_wstrb, s02_axi_wstrb, m00_axi_wstrb;
  logic s00_axi_awvalid, s01_axi_awvalid, s02_axi_awvalid, m00_axi_awvalid,
    s00_axi_awready, s01_axi_awready, s02_axi_awready, m00_axi_awready,
    s00_axi_wlast, s01_axi_wlast, s02_axi_wlast, m00_axi_wlast,
    s00_axi_wvalid, s01_axi_wvalid, s02_axi_wvalid, m00_axi_wvalid,
    s00_axi_wready, s01_axi_wready, s02_axi_wready, m00_axi_wready,
    s00_axi_bready, s01_axi_bready, s02_axi_bready, m00_axi_bready,
    s00_axi_bvalid, s01_axi_bvalid, s02_axi_bvalid, m00_axi_bvalid,
    s00_axi_arvalid, s01_axi_arvalid, s02_axi_arvalid, m00_axi_arvalid,
    s00_axi_arready, s01_axi_arready, s02_axi_arready, m00_axi_arready,
    s00_axi_rready, s01_axi_rready, s02_axi_rready, m00_axi_rready,
    s00_axi_rlast, s01_axi_rlast, s02_axi_rlast, m00_axi_rlast,
    s00_axi_rvalid, s01_axi_rvalid, s02_axi_rvalid, m00_axi_rvalid;

  logic [req_w-1:0]  req [3];
  logic [req_w-1:0]  m00_req;
  logic [resp_w-1:0] rsp;
  logic [resp_w-1:0] seen [3];
  logic [2:0]        prev_mask;
  logic              prev_live;
  integer            seed = 81465;
  int                errors = 0;
  int                checks = 0;
  int                cycle_cnt = 0;

  tmr_axi_vote tmr_axi_vote_inst (.*);

  assign {s00_axi_awid, s00_axi_awaddr, s00_axi_awlen, s00_axi_awsize, s00_axi_awburst,
          s00_axi_awvalid, s00_axi_wdata, s00_axi_wstrb, s00_axi_wlast, s00_axi_wvalid,
          s00_axi_arid, s00_axi_araddr, s00_axi_arlen, s00_axi_arsize, s00_axi_arburst,
          s00_axi_arvalid, s00_axi_bready, s00_axi_rready} = req[0];
  assign {s01_axi_awid, s01_axi_awaddr, s01_axi_awlen, s01_axi_awsize, s01_axi_awburst,
          s01_axi_awvalid, s01_axi_wdata, s01_axi_wstrb, s01_axi_wlast, s01_axi_wvalid,
          s01_axi_arid, s01_axi_araddr, s01_axi_arlen, s01_axi_arsize, s01_axi_arburst,
          s01_axi_arvalid, s01_axi_bready, s01_axi_rready} = req[1];
  assign {s02_axi_awid, s02_axi_awaddr, s02_axi_awlen, s02_axi_awsize, s02_axi_awburst,
          s02_axi_awvalid, s02_axi_wdata, s02_axi_wstrb, s02_axi_wlast, s02_axi_wvalid,
          s02_axi_arid, s02_axi_araddr, s02_axi_arlen, s02_axi_arsize, s02_axi_arburst,
          s02_axi_arvalid, s02_axi_bready, s02_axi_rready} = req[2];
  assign m00_req = {m00_axi_awid, m00_axi_awaddr, m00_axi_awlen, m00_axi_awsize,
                    m00_axi_awburst, m00_axi_awvalid, m00_axi_wdata, m00_axi_wstrb,
                    m00_axi_wlast, m00_axi_wvalid, m00_axi_arid, m00_axi_araddr,
                    m00_axi_arlen, m00_axi_arsize, m00_axi_arburst, m00_axi_arvalid,
                    m00_axi_bready, m00_axi_rready};

  assign {m00_axi_awready, m00_axi_wready, m00_axi_arready, m00_axi_bid, m00_axi_bresp,
          m00_axi_bvalid, m00_axi_rid, m00_axi_rdata, m00_axi_rresp, m00_axi_rlast,
          m00_axi_rvalid} = rsp;
  assign seen[0] = {s00_axi_awready, s00_axi_wready, s00_axi_arready, s00_axi_bid,
                    s00_axi_bresp, s00_axi_bvalid, s00_axi_rid, s00_axi_rdata,
                    s00_axi_rresp, s00_axi_rlast, s00_axi_rvalid};
  assign seen[1] = {s01_axi_awready, s01_axi_wready, s01_axi_arready, s01_axi_bid,
                    s01_axi_bresp, s01_axi_bvalid, s01_axi_rid, s01_axi_rdata,
                    s01_axi_rresp, s01_axi_rlast, s01_axi_rvalid};
  assign seen[2] = {s02_axi_awready, s02_axi_wready, s02_axi_arready, s02_axi_bid,
                    s02_axi_bresp, s02_axi_bvalid, s02_axi_rid, s02_axi_rdata,
                    s02_axi_rresp, s02_axi_rlast, s02_axi_rvalid};

  initial begin
    axi_aclk = 1'b0;
    forever #50 axi_aclk = ~axi_aclk;
  end

  // Bit-by-bit majority and odd-replica search
  function automatic logic [req_w-1:0] majority(input logic [req_w-1:0] r0, r1, r2);
    logic [req_w-1:0] m;
    for (int i = 0; i < req_w; i++) begin
      m[i] = (r0[i] == r1[i]) ? r0[i] : r2[i];
    end
    return m;
  endfunction

  function automatic logic [2:0] odd_replicas(input logic [req_w-1:0] r0, r1, r2);
    logic [2:0] m;
    m = 3'b000;
    for (int i = 0; i < req_w; i++) begin
      if (r1[i] == r2[i] && r0[i] != r1[i]) m[0] = 1'b1;
      if (r0[i] == r2[i] && r1[i] != r0[i]) m[1] = 1'b1;
      if (r0[i] == r1[i] && r2[i] != r0[i]) m[2] = 1'b1;
    end
    return m;
  endfunction

  function automatic int draw(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Random bit inside channel 0 rdy, 1 ar, 2 w, 3 aw
  task automatic pick_bit(input int ch, output int pos);
    case (ch)
      0: pos = draw(2);
      1: pos = 2 + draw(aw_w);
      2: pos = 2 + aw_w + draw(w_w);
      default: pos = 2 + aw_w + w_w + draw(aw_w);
    endcase
  endtask

  task automatic make_traffic();
    logic [159:0]       fill;
    logic [resp_w+31:0] rsp_fill;
    int mode, r1, r2, ch1, ch2, p1, p2;
    for (int i = 0; i < 5; i++) begin
      fill[i*32 +: 32] = $random(seed);
    end
    for (int i = 0; i < resp_w; i += 32) begin
      rsp_fill[i +: 32] = $random(seed);
    end
    for (int r = 0; r < 3; r++) begin
      req[r] = fill[req_w-1:0];
    end
    rsp = rsp_fill[resp_w-1:0];
    mode = draw(4);
    r1 = draw(3);
    r2 = (r1 + 1 + draw(2)) % 3;
    ch1 = draw(4);
    ch2 = (ch1 + 1 + draw(3)) % 4;
    pick_bit(ch1, p1);
    pick_bit(ch2, p2);
    case (mode)
      1: req[r1][p1] = ~req[r1][p1];
      2: begin
        req[r1][p1] = ~req[r1][p1];
        req[r2][p2] = ~req[r2][p2];
      end
      3: begin
        req[r1][p1] = ~req[r1][p1];
        req[r2][p1] = ~req[r2][p1];
      end
      default: ;
    endcase
  endtask

  task automatic check_cycle();
    logic [req_w-1:0] exp_req;
    logic [2:0]       exp_fault;
    exp_req = majority(req[0], req[1], req[2]);
    exp_fault = prev_live ? prev_mask : 3'b000;
    checks++;
    assert (m00_req === exp_req) else begin
      errors++;
      $display("Fail %0t m00_req: expected %h, actual %h", $time, exp_req, m00_req);
    end
    assert ({fault2, fault1, fault0} === exp_fault) else begin
      errors++;
      $display("Fail %0t fault2..fault0: expected %b, actual %b", $time, exp_fault,
               {fault2, fault1, fault0});
    end
    for (int r = 0; r < 3; r++) begin
      assert (seen[r] === rsp) else begin
        errors++;
        $display("Fail %0t seen[%0d]: expected %h, actual %h", $time, r,
                 rsp, seen[r]);
      end
    end
  endtask

  initial begin
    arst_n = 1'b0;
    req[0] = '0;
    req[1] = '0;
    req[2] = '0;
    rsp = '0;
    prev_mask = 3'b000;
    prev_live = 1'b0;
    for (int cyc = 0; cyc < total_cycles; cyc++) begin
      @(posedge axi_aclk);
      #5;
      arst_n = (cyc >= `TMR_TB_RST_CYCLES);
      make_traffic();
      #50;
      check_cycle();
      prev_live = arst_n;
      prev_mask = odd_replicas(req[0], req[1], req[2]);
    end
    $display("Cycles checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge axi_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tmr_axi_vote.f ====
+incdir+include
design/tmr_axi_pkg.sv
design/tmr_mismatch_if.sv
design/tmr_vote.sv
design/tmr_fault_flags.sv
design/tmr_axi_vote.sv
dv/tmr_axi_vote_assert.sv
dv/tmr_axi_vote_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tmr_axi_vote_tb
FILELIST  ?= tmr_axi_vote.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= TEST OK

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
